// ==== files.f ====
rtl/croc_pkg.sv
rtl/sram_bank.sv
rtl/main_xbar.sv
rtl/periph_demux.sv
rtl/soc_ctrl_regs.sv
rtl/gpio_regs.sv
rtl/croc_domain.sv
tb/croc_domain_props.sv
tb/tb_croc_domain.sv

// ==== rtl/croc_domain.sv ====
// SoC bus domain top level
`timescale 1ns/10ps

module croc_domain import croc_pkg::*; #(
  parameter int unsigned GpioCount    = 16,
  parameter int unsigned SramNumWords = 256
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 fetch_en_i,
  input  obi_req_t             host_req_i,
  output obi_rsp_t             host_rsp_o,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o,
  output logic                 gpio_irq_o,
  output logic                 fetch_enable_o,
  output addr_t                boot_addr_o
);

  // --------------------
  // Internal buses
  // --------------------
  obi_req_t sram_req;
  obi_rsp_t sram_rsp;
  obi_req_t periph_req;
  obi_rsp_t periph_rsp;
  obi_req_t soc_ctrl_req;
  obi_rsp_t soc_ctrl_rsp;
  obi_req_t gpio_req;
  obi_rsp_t gpio_rsp;

  main_xbar #(
    .SramNumWords ( SramNumWords )
  ) u_main_xbar (
    .clk_i,
    .rst_i,
    .host_req_i,
    .host_rsp_o,
    .sram_req_o   ( sram_req   ),
    .sram_rsp_i   ( sram_rsp   ),
    .periph_req_o ( periph_req ),
    .periph_rsp_i ( periph_rsp )
  );

  sram_bank #(
    .SramNumWords ( SramNumWords )
  ) u_sram_bank (
    .clk_i,
    .rst_i,
    .req_i ( sram_req ),
    .rsp_o ( sram_rsp )
  );

  periph_demux u_periph_demux (
    .clk_i,
    .rst_i,
    .periph_req_i   ( periph_req   ),
    .periph_rsp_o   ( periph_rsp   ),
    .soc_ctrl_req_o ( soc_ctrl_req ),
    .soc_ctrl_rsp_i ( soc_ctrl_rsp ),
    .gpio_req_o     ( gpio_req     ),
    .gpio_rsp_i     ( gpio_rsp     )
  );

  soc_ctrl_regs u_soc_ctrl_regs (
    .clk_i,
    .rst_i,
    .req_i ( soc_ctrl_req ),
    .rsp_o ( soc_ctrl_rsp ),
    .fetch_en_i,
    .fetch_enable_o,
    .boot_addr_o
  );

  gpio_regs #(
    .GpioCount ( GpioCount )
  ) u_gpio_regs (
    .clk_i,
    .rst_i,
    .req_i ( gpio_req ),
    .rsp_o ( gpio_rsp ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o,
    .gpio_irq_o
  );

endmodule

// ==== rtl/croc_pkg.sv ====
// SoC bus domain shared definitions
package croc_pkg;

  // --------------------
  // Bus types
  // --------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // Request channel, sampled while req is high
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  // Response channel, valid for one cycle
  typedef struct packed {
    logic  rvalid;
    logic  err;
    data_t rdata;
  } obi_rsp_t;

  // --------------------
  // Address map
  // --------------------
  localparam addr_t SramBaseAddr    = 32'h1000_0000;
  localparam addr_t PeriphBaseAddr  = 32'h0300_0000;  // 64 KiB region
  localparam addr_t SocCtrlBaseAddr = 32'h0300_0000;  // 4 KiB window
  localparam addr_t GpioBaseAddr    = 32'h0300_1000;  // 4 KiB window

  // Returned by both error subordinates
  localparam data_t ErrRspData = 32'hBADCAB1E;

  // Main interconnect targets
  typedef enum logic [1:0] {XbarError, XbarPeriph, XbarSram} xbar_sel_e;

  // Peripheral demux targets
  typedef enum logic [1:0] {PeriphError, PeriphSocCtrl, PeriphGpio} periph_sel_e;

  // SoC control word offsets
  typedef enum logic [3:0] {
    SocCtrlBootAddr = 4'h0,
    SocCtrlFetchEn  = 4'h4
  } soc_ctrl_reg_e;

  // GPIO word offsets
  typedef enum logic [4:0] {
    GpioDir       = 5'h00,
    GpioOut       = 5'h04,
    GpioIn        = 5'h08,
    GpioIrqEn     = 5'h0C,
    GpioIrqStatus = 5'h10
  } gpio_reg_e;

endpackage

// ==== rtl/gpio_regs.sv ====
// GPIO register block
`timescale 1ns/10ps

module gpio_regs import croc_pkg::*; #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  obi_req_t             req_i,
  output obi_rsp_t             rsp_o,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o,
  output logic                 gpio_irq_o
);

  gpio_reg_e             reg_sel;
  logic                  reg_hit;
  logic                  reg_we;
  logic [GpioCount-1:0]  wdata;
  logic [GpioCount-1:0]  dir_q, out_q, irq_en_q, irq_status_q;
  logic [GpioCount-1:0]  sync1_q, sync2_q, prev_q;
  logic [GpioCount-1:0]  rise;
  logic                  rvalid_q;
  data_t                 rdata_q;

  assign reg_sel = gpio_reg_e'(req_i.addr[4:0]);
  assign reg_hit = (req_i.addr[11:5] == '0);
  assign reg_we  = req_i.req && req_i.we && reg_hit;
  assign wdata   = req_i.wdata[GpioCount-1:0];

  // --------------------
  // Input sync and edges
  // --------------------
  assign rise = sync2_q & ~prev_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dir_q        <= '0;
      out_q        <= '0;
      irq_en_q     <= '0;
      irq_status_q <= '0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      if (reg_we && (reg_sel == GpioDir)) begin
        dir_q <= wdata;
      end
      if (reg_we && (reg_sel == GpioOut)) begin
        out_q <= wdata;
      end
      if (reg_we && (reg_sel == GpioIrqEn)) begin
        irq_en_q <= wdata;
      end
      // New edges win over a clear in the same cycle
      if (reg_we && (reg_sel == GpioIrqStatus)) begin
        irq_status_q <= (irq_status_q & ~wdata) | (rise & irq_en_q);
      end else begin
        irq_status_q <= irq_status_q | (rise & irq_en_q);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= '0;
      if (!req_i.we && reg_hit) begin
        case (reg_sel)
          GpioDir:       rdata_q <= data_t'(dir_q);
          GpioOut:       rdata_q <= data_t'(out_q);
          GpioIn:        rdata_q <= data_t'(sync2_q);
          GpioIrqEn:     rdata_q <= data_t'(irq_en_q);
          GpioIrqStatus: rdata_q <= data_t'(irq_status_q);
          default: ;
        endcase
      end
    end
  end

  assign rsp_o          = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};
  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = sync2_q;
  assign gpio_irq_o     = |irq_status_q;

endmodule

// ==== rtl/main_xbar.sv ====
// Main address-decoding interconnect
`timescale 1ns/10ps

module main_xbar import croc_pkg::*; #(
  parameter int unsigned SramNumWords = 256
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  obi_req_t host_req_i,
  output obi_rsp_t host_rsp_o,
  output obi_req_t sram_req_o,
  input  obi_rsp_t sram_rsp_i,
  output obi_req_t periph_req_o,
  input  obi_rsp_t periph_rsp_i
);

  // First byte past the SRAM
  localparam addr_t SramEndAddr = addr_t'(SramBaseAddr + SramNumWords * 4);

  xbar_sel_e sel_d;
  xbar_sel_e sel_q;
  logic      err_valid_q;
  obi_rsp_t  err_rsp;

  // --------------------
  // Request decode
  // --------------------
  always_comb begin
    if ((host_req_i.addr >= SramBaseAddr) && (host_req_i.addr < SramEndAddr)) begin
      sel_d = XbarSram;
    end else if (host_req_i.addr[31:16] == PeriphBaseAddr[31:16]) begin
      sel_d = XbarPeriph;
    end else begin
      sel_d = XbarError;
    end
  end

  // Only the selected target sees req
  always_comb begin
    sram_req_o       = host_req_i;
    sram_req_o.req   = host_req_i.req && (sel_d == XbarSram);
    periph_req_o     = host_req_i;
    periph_req_o.req = host_req_i.req && (sel_d == XbarPeriph);
  end

  // Target of the response due next cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_q <= XbarError;
    end else if (host_req_i.req) begin
      sel_q <= sel_d;
    end
  end

  // --------------------
  // Error subordinate
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_valid_q <= 1'b0;
    end else begin
      err_valid_q <= host_req_i.req && (sel_d == XbarError);
    end
  end

  assign err_rsp = '{rvalid: err_valid_q, err: err_valid_q, rdata: ErrRspData};

  // Response return
  always_comb begin
    unique case (sel_q)
      XbarSram:   host_rsp_o = sram_rsp_i;
      XbarPeriph: host_rsp_o = periph_rsp_i;
      default:    host_rsp_o = err_rsp;
    endcase
  end

endmodule

// ==== rtl/periph_demux.sv ====
// Peripheral region demultiplexer
`timescale 1ns/10ps

module periph_demux import croc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  obi_req_t periph_req_i,
  output obi_rsp_t periph_rsp_o,
  output obi_req_t soc_ctrl_req_o,
  input  obi_rsp_t soc_ctrl_rsp_i,
  output obi_req_t gpio_req_o,
  input  obi_rsp_t gpio_rsp_i
);

  periph_sel_e sel_d;
  periph_sel_e sel_q;
  logic        err_valid_q;
  obi_rsp_t    err_rsp;

  // 4 KiB window decode
  always_comb begin
    if (periph_req_i.addr[31:12] == SocCtrlBaseAddr[31:12]) begin
      sel_d = PeriphSocCtrl;
    end else if (periph_req_i.addr[31:12] == GpioBaseAddr[31:12]) begin
      sel_d = PeriphGpio;
    end else begin
      sel_d = PeriphError;
    end
  end

  always_comb begin
    soc_ctrl_req_o     = periph_req_i;
    soc_ctrl_req_o.req = periph_req_i.req && (sel_d == PeriphSocCtrl);
    gpio_req_o         = periph_req_i;
    gpio_req_o.req     = periph_req_i.req && (sel_d == PeriphGpio);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_q       <= PeriphError;
      err_valid_q <= 1'b0;
    end else begin
      err_valid_q <= periph_req_i.req && (sel_d == PeriphError);
      if (periph_req_i.req) begin
        sel_q <= sel_d;
      end
    end
  end

  // Unclaimed part of the region
  assign err_rsp = '{rvalid: err_valid_q, err: err_valid_q, rdata: ErrRspData};

  always_comb begin
    unique case (sel_q)
      PeriphSocCtrl: periph_rsp_o = soc_ctrl_rsp_i;
      PeriphGpio:    periph_rsp_o = gpio_rsp_i;
      default:       periph_rsp_o = err_rsp;
    endcase
  end

endmodule

// ==== rtl/soc_ctrl_regs.sv ====
// SoC control registers
`timescale 1ns/10ps

module soc_ctrl_regs import croc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  obi_req_t req_i,
  output obi_rsp_t rsp_o,
  input  logic     fetch_en_i,
  output logic     fetch_enable_o,
  output addr_t    boot_addr_o
);

  soc_ctrl_reg_e reg_sel;
  logic          reg_hit;
  addr_t         boot_addr_q;
  logic          fetch_en_q;
  logic          rvalid_q;
  data_t         rdata_q;

  // Only the first 16 bytes of the window hold registers
  assign reg_sel = soc_ctrl_reg_e'(req_i.addr[3:0]);
  assign reg_hit = (req_i.addr[11:4] == '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      boot_addr_q <= SramBaseAddr;
      fetch_en_q  <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      if (req_i.req && req_i.we && reg_hit) begin
        case (reg_sel)
          SocCtrlBootAddr: boot_addr_q <= req_i.wdata;
          SocCtrlFetchEn:  fetch_en_q  <= req_i.wdata[0];
          default: ;
        endcase
      end
    end
  end

  // Readback, unknown offsets give 0
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= '0;
      if (!req_i.we && reg_hit) begin
        case (reg_sel)
          SocCtrlBootAddr: rdata_q <= boot_addr_q;
          SocCtrlFetchEn:  rdata_q <= data_t'(fetch_en_q);
          default: ;
        endcase
      end
    end
  end

  assign rsp_o          = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};
  assign boot_addr_o    = boot_addr_q;
  assign fetch_enable_o = fetch_en_q | fetch_en_i;

endmodule

// ==== rtl/sram_bank.sv ====
// Single-bank word SRAM
`timescale 1ns/10ps

module sram_bank import croc_pkg::*; #(
  parameter int unsigned SramNumWords = 256
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  obi_req_t req_i,
  output obi_rsp_t rsp_o
);

  localparam int unsigned IdxWidth = $clog2(SramNumWords);

  data_t                mem_q [SramNumWords];
  logic  [IdxWidth-1:0] word_idx;
  logic                 rvalid_q;
  data_t                rdata_q;

  // Byte address to word index
  assign word_idx = req_i.addr[IdxWidth+1:2];

  // Byte-enabled write
  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read data, zero for writes
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : mem_q[word_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

endmodule

// ==== tb/croc_domain_props.sv ====
// Host bus protocol assertions
`timescale 1ns/10ps

module croc_domain_props import croc_pkg::*; (
  input logic     clk_i,
  input logic     rst_i,
  input obi_req_t host_req_i,
  input obi_rsp_t host_rsp_i
);

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // One response per request, exactly one cycle later
  rsp_follows_req: assert property (
    @(posedge clk_i) disable iff (rst_i) host_rsp_i.rvalid == $past(host_req_i.req)
  ) else begin
    $error("rvalid does not match the request of the previous cycle");
    fail_count++;
  end

  rsp_quiet_after_reset: assert property (
    @(posedge clk_i) $fell(rst_i) |-> !host_rsp_i.rvalid
  ) else begin
    $error("rvalid is high in the cycle after reset");
    fail_count++;
  end

  // Error responses carry the fixed error word
  err_data: assert property (
    @(posedge clk_i) disable iff (rst_i) host_rsp_i.err |-> host_rsp_i.rdata == ErrRspData
  ) else begin
    $error("error response without the error data word");
    fail_count++;
  end

endmodule

bind croc_domain croc_domain_props u_croc_domain_props (
  .clk_i,
  .rst_i,
  .host_req_i,
  .host_rsp_i ( host_rsp_o )
);

// ==== tb/tb_croc_domain.sv ====
// SoC bus domain testbench
`timescale 1ns/10ps

module tb_croc_domain import croc_pkg::*; ();

  localparam int unsigned GpioCount    = 16;
  localparam int unsigned SramNumWords = 256;
  localparam int          Timeout      = 20;

  typedef logic [GpioCount-1:0] gpio_t;

  logic     clk_i;
  logic     rst_i;
  logic     fetch_en_i;
  obi_req_t host_req_i;
  obi_rsp_t host_rsp_o;
  gpio_t    gpio_i;
  gpio_t    gpio_o;
  gpio_t    gpio_out_en_o;
  gpio_t    gpio_in_sync_o;
  logic     gpio_irq_o;
  logic     fetch_enable_o;
  addr_t    boot_addr_o;

  // Words left in the SRAM by the SRAM test
  addr_t sram_addr [4];
  data_t sram_word [4];

  croc_domain #(
    .GpioCount    ( GpioCount    ),
    .SramNumWords ( SramNumWords )
  ) u_croc_domain (
    .clk_i,
    .rst_i,
    .fetch_en_i,
    .host_req_i,
    .host_rsp_o,
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o,
    .gpio_irq_o,
    .fetch_enable_o,
    .boot_addr_o
  );

  always #4 clk_i = ~clk_i;

  // --------------------
  // Compare tasks
  // --------------------
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_err(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("CHECK FAILED %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  task automatic check_gpio(input string name, input gpio_t expected, input gpio_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // Single-bit output pins
  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("CHECK FAILED %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  // --------------------
  // Bus tasks
  // --------------------
  task automatic bus_access(input string name, input logic is_write, input be_t byte_en,
                            input addr_t address, input data_t write_data,
                            output data_t rsp_data, output logic rsp_err);
    int cycles;
    @(negedge clk_i);
    host_req_i = '{req: 1'b1, we: is_write, be: byte_en, addr: address, wdata: write_data};
    @(negedge clk_i);
    host_req_i = '0;
    cycles = 0;
    while (!host_rsp_o.rvalid) begin
      if (cycles == Timeout) begin
        report_failure($sformatf("No bus response to the request in %s", name));
      end
      @(negedge clk_i);
      cycles++;
    end
    rsp_data = host_rsp_o.rdata;
    rsp_err  = host_rsp_o.err;
  endtask

  task automatic write_word(input string name, input addr_t address, input data_t value);
    data_t rd;
    logic  err;
    bus_access(name, 1'b1, 4'hF, address, value, rd, err);
    check_err(name, 1'b0, err);
    // Write responses carry no data
    check_data(name, '0, rd);
  endtask

  task automatic read_word(input string name, input addr_t address, output data_t value);
    logic err;
    bus_access(name, 1'b0, 4'hF, address, '0, value, err);
    check_err(name, 1'b0, err);
  endtask

  task automatic wait_gpio_sync(input gpio_t expected);
    int cycles;
    cycles = 0;
    while (gpio_in_sync_o !== expected) begin
      if (cycles == Timeout) begin
        report_failure("Timeout: gpio_in_sync_o did not follow gpio_i");
      end
      @(negedge clk_i);
      cycles++;
    end
  endtask

  task automatic wait_irq(input logic expected);
    int cycles;
    cycles = 0;
    while (gpio_irq_o !== expected) begin
      if (cycles == Timeout) begin
        report_failure($sformatf("Timeout: gpio_irq_o did not become %b", expected));
      end
      @(negedge clk_i);
      cycles++;
    end
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_sram();
    data_t rd;
    logic  err;
    // Distinct word indices, one per quarter of the bank
    for (int i = 0; i < 4; i++) begin
      sram_addr[i] = addr_t'(SramBaseAddr + (i * 64 + ($urandom % 64)) * 4);
      sram_word[i] = $urandom;
      write_word("sram write", sram_addr[i], sram_word[i]);
    end
    for (int i = 0; i < 4; i++) begin
      read_word("sram read", sram_addr[i], rd);
      check_data("sram readback", sram_word[i], rd);
    end
    // Bytes 0 and 2 only
    write_word("sram partial", sram_addr[0], 32'h1122_3344);
    bus_access("sram partial", 1'b1, 4'b0101, sram_addr[0], 32'hAABB_CCDD, rd, err);
    check_err("sram partial write", 1'b0, err);
    sram_word[0] = 32'h11BB_33DD;
    read_word("sram partial", sram_addr[0], rd);
    check_data("sram partial readback", sram_word[0], rd);
  endtask

  task automatic test_pipeline();
    @(negedge clk_i);
    for (int i = 0; i < 4; i++) begin
      host_req_i = '{req: 1'b1, we: 1'b0, be: 4'hF, addr: sram_addr[i], wdata: '0};
      @(negedge clk_i);
      if (!host_rsp_o.rvalid) begin
        report_failure($sformatf("Pipelined read %0d got no response in the next cycle", i));
      end
      check_err("pipeline err", 1'b0, host_rsp_o.err);
      check_data("pipeline data", sram_word[i], host_rsp_o.rdata);
    end
    host_req_i = '0;
  endtask

  task automatic test_soc_ctrl();
    addr_t new_boot;
    data_t rd;
    logic  reg_bit;
    check_addr("soc_ctrl boot after reset", SramBaseAddr, boot_addr_o);
    new_boot = addr_t'(SramBaseAddr + ($urandom % SramNumWords) * 4);
    write_word("soc_ctrl boot", SocCtrlBaseAddr + SocCtrlBootAddr, new_boot);
    check_addr("soc_ctrl boot_addr_o", new_boot, boot_addr_o);
    read_word("soc_ctrl boot", SocCtrlBaseAddr + SocCtrlBootAddr, rd);
    check_data("soc_ctrl boot readback", new_boot, rd);
    // Register and pin, all four combinations
    for (int combo = 0; combo < 4; combo++) begin
      reg_bit    = combo[1];
      fetch_en_i = combo[0];
      write_word("soc_ctrl fetch", SocCtrlBaseAddr + SocCtrlFetchEn, data_t'(reg_bit));
      check_flag("soc_ctrl fetch_enable_o", reg_bit | fetch_en_i, fetch_enable_o);
      read_word("soc_ctrl fetch", SocCtrlBaseAddr + SocCtrlFetchEn, rd);
      check_data("soc_ctrl fetch readback", data_t'(reg_bit), rd);
    end
    fetch_en_i = 1'b0;
  endtask

  task automatic test_gpio_io();
    gpio_t dir_val;
    gpio_t out_val;
    gpio_t in_val;
    data_t rd;
    dir_val = gpio_t'($urandom);
    out_val = gpio_t'($urandom);
    in_val  = gpio_t'($urandom);
    write_word("gpio dir", GpioBaseAddr + GpioDir, data_t'(dir_val));
    write_word("gpio out", GpioBaseAddr + GpioOut, data_t'(out_val));
    check_gpio("gpio gpio_out_en_o", dir_val, gpio_out_en_o);
    check_gpio("gpio gpio_o", out_val, gpio_o);
    read_word("gpio dir", GpioBaseAddr + GpioDir, rd);
    check_data("gpio dir readback", data_t'(dir_val), rd);
    gpio_i = in_val;
    wait_gpio_sync(in_val);
    read_word("gpio in", GpioBaseAddr + GpioIn, rd);
    check_data("gpio in readback", data_t'(in_val), rd);
  endtask

  task automatic test_gpio_irq();
    gpio_t mask;
    gpio_t pattern;
    data_t rd;
    mask    = gpio_t'($urandom) | gpio_t'(1);
    pattern = gpio_t'($urandom) | gpio_t'(1);
    gpio_i = '0;
    wait_gpio_sync('0);
    write_word("gpio irq en", GpioBaseAddr + GpioIrqEn, data_t'(mask));
    gpio_i = pattern;
    wait_irq(1'b1);
    read_word("gpio irq status", GpioBaseAddr + GpioIrqStatus, rd);
    check_data("gpio irq status set", data_t'(pattern & mask), rd);
    // Write 1 to clear
    write_word("gpio irq clear", GpioBaseAddr + GpioIrqStatus, data_t'(pattern & mask));
    wait_irq(1'b0);
    read_word("gpio irq status", GpioBaseAddr + GpioIrqStatus, rd);
    check_data("gpio irq status cleared", '0, rd);
  endtask

  task automatic test_error_paths();
    data_t rd;
    logic  err;
    bus_access("error unmapped", 1'b0, 4'hF, 32'h2000_0000, '0, rd, err);
    check_err("error unmapped err", 1'b1, err);
    check_data("error unmapped data", ErrRspData, rd);
    bus_access("error sram end", 1'b0, 4'hF, SramBaseAddr + SramNumWords * 4, '0, rd, err);
    check_err("error sram end err", 1'b1, err);
    check_data("error sram end data", ErrRspData, rd);
    bus_access("error write", 1'b1, 4'hF, 32'h2000_0010, $urandom, rd, err);
    check_err("error write err", 1'b1, err);
    bus_access("error periph", 1'b0, 4'hF, PeriphBaseAddr + 32'h8000, '0, rd, err);
    check_err("error periph err", 1'b1, err);
    check_data("error periph data", ErrRspData, rd);
    // Mapped targets still answer without error
    read_word("error mapped sram", sram_addr[1], rd);
    check_data("error mapped sram data", sram_word[1], rd);
    read_word("error mapped soc_ctrl", SocCtrlBaseAddr + SocCtrlFetchEn, rd);
    read_word("error mapped gpio", GpioBaseAddr + GpioDir, rd);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    void'($urandom(32'h17cf));
    clk_i      = 1'b0;
    rst_i      = 1'b1;
    fetch_en_i = 1'b0;
    host_req_i = '0;
    gpio_i     = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    test_soc_ctrl();
    test_sram();
    test_pipeline();
    test_gpio_io();
    test_gpio_irq();
    test_error_paths();

    @(negedge clk_i);
    if (u_croc_domain.u_croc_domain_props.fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Bus protocol assertions failed during the run");
      $display("Test FAILED");
      $fatal(1);
    end
  end

endmodule
